// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module rvCoreTb -f filelist.f -o simv

run: compile
	./obj_dir/simv | tee sim.log
	@if grep -q "Test FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" sim.log; then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: controlUnit.sv
`timescale 1ns/10ps
`include "rvCore_macros.svh"

module controlUnit import rvCorePkg::*; (
    input  logic [`XLEN-1:0] instr,
    decodeIf.decoder         dec
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb
    begin
        dec.regWrite  = 1'b0; // everything idle unless decoded below
        dec.aluCtrl   = aluAdd;
        dec.aluSrc    = 1'b0;
        dec.immSrc    = immI;
        dec.memWrite  = 1'b0;
        dec.resultSrc = 1'b0;
        dec.branch    = 1'b0;
        dec.jump      = 1'b0;
        dec.branchNe  = 1'b0;

        case (opcodeT'(instr[6:0]))
            opImm:
                if (funct3 == 3'b000) // addi only
                begin
                    dec.regWrite = 1'b1;
                    dec.aluSrc   = 1'b1;
                end
            opReg:
                if (funct7 == 7'b0100000 && funct3 == 3'b000) // sub
                begin
                    dec.regWrite = 1'b1;
                    dec.aluCtrl  = aluSub;
                end
                else if (funct7 == 7'b0000000)
                begin
                    dec.regWrite = 1'b1; // cleared again for unsupported funct3
                    case (funct3)
                        3'b000: dec.aluCtrl = aluAdd;
                        3'b010: dec.aluCtrl = aluSlt;
                        3'b100: dec.aluCtrl = aluXor;
                        3'b110: dec.aluCtrl = aluOr;
                        3'b111: dec.aluCtrl = aluAnd;
                        default: dec.regWrite = 1'b0; // shifts, sltu
                    endcase
                end
            opLoad:
                if (funct3 == 3'b010) // lw with address rs1 + imm
                begin
                    dec.regWrite  = 1'b1;
                    dec.aluSrc    = 1'b1;
                    dec.resultSrc = 1'b1;
                end
            opStore:
                if (funct3 == 3'b010) // sw
                begin
                    dec.memWrite = 1'b1;
                    dec.aluSrc   = 1'b1;
                    dec.immSrc   = immS;
                end
            opBranch:
                if (funct3 == 3'b000 || funct3 == 3'b001) // beq, bne
                begin
                    dec.branch   = 1'b1;
                    dec.branchNe = funct3[0];
                    dec.immSrc   = immB;
                end
            opJal:
            begin
                dec.regWrite = 1'b1; // link register gets pc + 4
                dec.jump     = 1'b1;
                dec.immSrc   = immJ;
            end
            opLui:
            begin
                dec.regWrite = 1'b1;
                dec.aluCtrl  = aluPassB;
                dec.aluSrc   = 1'b1;
                dec.immSrc   = immU;
            end
            default: ; // unsupported opcode acts as a no-op
        endcase
    end

endmodule

// File: coreIfs.sv
`timescale 1ns/10ps
`include "rvCore_macros.svh"

// controls from the decoder, split between imm generation and execute
interface decodeIf import rvCorePkg::*; ();
    logic   regWrite;
    aluOpT  aluCtrl;
    logic   aluSrc;    // 1 selects imm as alu operand b
    immSrcT immSrc;
    logic   memWrite;
    logic   resultSrc; // 1 selects load data
    logic   branch;
    logic   jump;      // jal
    logic   branchNe;  // invert the equality test

    modport decoder (
        output regWrite, aluCtrl, aluSrc, immSrc, memWrite,
        output resultSrc, branch, jump, branchNe
    );

    modport immUser (input immSrc);

    modport exec (
        input regWrite, aluCtrl, aluSrc, memWrite,
        input resultSrc, branch, jump, branchNe
    );
endinterface

// register operands and immediate of the current instruction
interface operandIf ();
    logic [`XLEN-1:0]               rs1Data;
    logic [`XLEN-1:0]               rs2Data;
    logic [`XLEN-1:0]               imm;
    logic [$clog2(`REG_COUNT)-1:0] rdAddr;

    modport source (output rs1Data, rs2Data, imm, rdAddr);
    modport sink (input rs1Data, rs2Data, imm, rdAddr);
endinterface

// File: executeUnit.sv
`timescale 1ns/10ps
`include "rvCore_macros.svh"

module executeUnit import rvCorePkg::*; (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          instrValid,
    decodeIf.exec                         dec,
    operandIf.sink                        ops,
    input  logic [`XLEN-1:0]              memRdata,
    output logic [`XLEN-1:0]              pc,
    output logic                          wbEn,
    output logic [$clog2(`REG_COUNT)-1:0] wbAddr,
    output logic [`XLEN-1:0]              wbData,
    output logic                          memWriteEn,
    output logic [`XLEN-1:0]              memAddr,
    output logic [`XLEN-1:0]              memWdata
);

    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcTarget;
    logic [`XLEN-1:0] pcNext;
    logic             branchTaken;

    assign srcB = dec.aluSrc ? ops.imm : ops.rs2Data; // imm for addi, lw, sw, lui

    always_comb
    begin
        case (dec.aluCtrl)
            aluSub:   aluResult = ops.rs1Data - srcB;
            aluAnd:   aluResult = ops.rs1Data & srcB;
            aluOr:    aluResult = ops.rs1Data | srcB;
            aluXor:   aluResult = ops.rs1Data ^ srcB;
            aluSlt:   aluResult = {{(`XLEN-1){1'b0}},
                                   $signed(ops.rs1Data) < $signed(srcB)};
            aluPassB: aluResult = srcB;
            default:  aluResult = ops.rs1Data + srcB;
        endcase
    end

    // beq takes on equal, bne on unequal
    assign branchTaken = dec.branch && ((ops.rs1Data == ops.rs2Data) ^ dec.branchNe);

    assign pcPlus4  = pc + `XLEN'd4;
    assign pcTarget = pc + ops.imm; // B or J offset
    assign pcNext   = (dec.jump || branchTaken) ? pcTarget : pcPlus4;

    // pc only moves on a valid instruction
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            pc <= `RESET_PC;
        end
        else if (instrValid)
        begin
            pc <= pcNext;
        end
    end

    always_comb
    begin
        if (dec.jump)
            wbData = pcPlus4; // link address
        else if (dec.resultSrc)
            wbData = memRdata; // lw passes the word through
        else
            wbData = aluResult;
    end

    assign wbAddr = ops.rdAddr;
    assign wbEn   = instrValid && dec.regWrite && (ops.rdAddr != '0); // drop x0

    assign memWriteEn = instrValid && dec.memWrite;
    assign memAddr    = aluResult; // rs1 + imm for lw and sw
    assign memWdata   = ops.rs2Data;

    // next pc takes the target from one source only
    assert property (@(posedge clk) disable iff (!arstN) !(dec.jump && dec.branch))
        else $error("decoder raised jump and branch together");

    // no decoded instruction both stores and writes a register
    assert property (@(posedge clk) disable iff (!arstN) !(memWriteEn && wbEn))
        else $error("store and register write-back in the same cycle");

endmodule

// File: filelist.f
+incdir+.
rvCorePkg.sv
coreIfs.sv
controlUnit.sv
operandFetch.sv
executeUnit.sv
rvCore.sv
rvCoreChecker.sv
rvCoreTb.sv

// File: operandFetch.sv
`timescale 1ns/10ps
`include "rvCore_macros.svh"

module operandFetch import rvCorePkg::*; (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic [`XLEN-1:0]              instr,
    decodeIf.immUser                      dec,
    operandIf.source                      ops,
    input  logic                          wbEn,
    input  logic [$clog2(`REG_COUNT)-1:0] wbAddr,
    input  logic [`XLEN-1:0]              wbData
);

    localparam int REG_AW = $clog2(`REG_COUNT);

    logic [`XLEN-1:0]  regs [0:`REG_COUNT-1];
    logic [REG_AW-1:0] rs1Addr;
    logic [REG_AW-1:0] rs2Addr;

    assign rs1Addr    = instr[15+REG_AW-1:15];
    assign rs2Addr    = instr[20+REG_AW-1:20];
    assign ops.rdAddr = instr[7+REG_AW-1:7];

    // register file, whole array cleared on reset
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wbEn && wbAddr != '0) // x0 stays zero
        begin
            regs[wbAddr] <= wbData;
        end
    end

    // two async read ports, x0 hardwired
    assign ops.rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign ops.rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

    // sign-extended immediate per format
    always_comb
    begin
        case (dec.immSrc)
            immS:
                ops.imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            immB:
                ops.imm = {{(`XLEN-13){instr[31]}}, instr[31], instr[7],
                           instr[30:25], instr[11:8], 1'b0};
            immJ:
                ops.imm = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12],
                           instr[20], instr[30:21], 1'b0};
            immU:
                ops.imm = {instr[31:12], {(`XLEN-20){1'b0}}}; // upper 20 bits
            default:
                ops.imm = {{(`XLEN-12){instr[31]}}, instr[31:20]}; // I format
        endcase
    end

    // execute must already suppress wbEn for rd == x0
    assert property (@(posedge clk) disable iff (!arstN) !(wbEn && wbAddr == '0))
        else $error("write-back to x0 reached the register file");

endmodule

// File: rvCore.sv
`timescale 1ns/10ps
`include "rvCore_macros.svh"

module rvCore (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic [`XLEN-1:0]              instr,
    input  logic                          instrValid, // low stalls the core
    output logic [`XLEN-1:0]              pc,
    output logic                          wbEn,
    output logic [$clog2(`REG_COUNT)-1:0] wbAddr,
    output logic [`XLEN-1:0]              wbData,
    output logic                          memWriteEn,
    output logic [`XLEN-1:0]              memAddr,
    output logic [`XLEN-1:0]              memWdata,
    input  logic [`XLEN-1:0]              memRdata    // same-cycle load data
);

    decodeIf  decBus ();
    operandIf opBus ();

    controlUnit uControl (
        .instr (instr),
        .dec   (decBus.decoder)
    );

    // decodes alongside the control unit, write-back loops in from execute
    operandFetch uOperands (
        .clk    (clk),
        .arstN  (arstN),
        .instr  (instr),
        .dec    (decBus.immUser),
        .ops    (opBus.source),
        .wbEn   (wbEn),
        .wbAddr (wbAddr),
        .wbData (wbData)
    );

    executeUnit uExecute (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .dec        (decBus.exec),
        .ops        (opBus.sink),
        .memRdata   (memRdata),
        .pc         (pc),
        .wbEn       (wbEn),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .memWriteEn (memWriteEn),
        .memAddr    (memAddr),
        .memWdata   (memWdata)
    );

endmodule

// File: rvCoreChecker.sv
`timescale 1ns/10ps
`include "rvCore_macros.svh"

module rvCoreChecker import rvCorePkg::*; (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic [`XLEN-1:0]              instr,
    input  logic                          instrValid,
    input  logic [`XLEN-1:0]              pc,
    input  logic                          wbEn,
    input  logic [$clog2(`REG_COUNT)-1:0] wbAddr,
    input  logic [`XLEN-1:0]              wbData,
    input  logic                          memWriteEn,
    input  logic [`XLEN-1:0]              memAddr,
    input  logic [`XLEN-1:0]              memWdata,
    input  logic [`XLEN-1:0]              memRdata,
    input  logic                          done,
    output int                            errorTotal,
    output int                            checkTotal
);

    typedef struct packed {
        logic [`XLEN-1:0] pcNext;
        logic             wbEn;
        logic [4:0]       wbAddr;
        logic [`XLEN-1:0] wbData;
        logic             memWe;
        logic             chkAddr; // lw and sw put out an address
        logic [`XLEN-1:0] memAddr;
        logic [`XLEN-1:0] memWdata;
        logic [2:0]       kind;    // which test the cycle counts for
    } expectT;

    string            testNames [0:4] = '{"reset state", "alu and immediate", "memory access",
                                          "control flow", "stall and unsupported"};
    int               checks [0:4] = '{default: 0};
    int               errs [0:4] = '{default: 0};
    logic [`XLEN-1:0] modelRegs [0:`REG_COUNT-1];
    logic [`XLEN-1:0] modelPc;
    expectT           expected;

    always_comb errorTotal = errs[0] + errs[1] + errs[2] + errs[3] + errs[4];
    always_comb checkTotal = checks[0] + checks[1] + checks[2] + checks[3] + checks[4];

    // expected effect of one instruction; a, b are the model's rs1, rs2 values
    function automatic expectT refModel(input logic [31:0] ins, input logic [31:0] curPc,
                                        input logic [31:0] a, input logic [31:0] b,
                                        input logic [31:0] rdata, input logic valid);
        expectT      r;
        logic [31:0] iImm;
        logic [31:0] sImm;
        logic [31:0] bImm;
        logic [31:0] jImm;
        iImm     = {{20{ins[31]}}, ins[31:20]};
        sImm     = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        bImm     = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        jImm     = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        r        = '0;
        r.pcNext = curPc + 32'd4; // default for everything but taken jumps
        r.wbAddr = ins[11:7];
        r.kind   = 3'd4;
        case (ins[6:0])
            opImm:
                if (ins[14:12] == 3'b000)
                begin
                    r = '{pcNext: r.pcNext, wbEn: 1'b1, wbAddr: r.wbAddr, wbData: a + iImm,
                          default: '0};
                    r.kind = 3'd1;
                end
            opReg:
            begin
                r.kind = 3'd1;
                r.wbEn = 1'b1;
                case ({ins[31:25], ins[14:12]})
                    10'b0000000_000: r.wbData = a + b;
                    10'b0100000_000: r.wbData = a - b;
                    10'b0000000_111: r.wbData = a & b;
                    10'b0000000_110: r.wbData = a | b;
                    10'b0000000_100: r.wbData = a ^ b;
                    10'b0000000_010: r.wbData = {31'b0, $signed(a) < $signed(b)};
                    default:         r.kind = 3'd4; // shifts, sltu and the rest
                endcase
            end
            opLoad:
                if (ins[14:12] == 3'b010)
                begin
                    r.wbEn    = 1'b1;
                    r.wbData  = rdata; // word returned unchanged
                    r.chkAddr = 1'b1;
                    r.memAddr = a + iImm;
                    r.kind    = 3'd2;
                end
            opStore:
                if (ins[14:12] == 3'b010)
                begin
                    r.memWe    = 1'b1;
                    r.chkAddr  = 1'b1;
                    r.memAddr  = a + sImm;
                    r.memWdata = b;
                    r.kind     = 3'd2;
                end
            opBranch:
                if (ins[14:13] == 2'b00) // beq, bne
                begin
                    r.kind = 3'd3;
                    if ((a == b) != ins[12])
                        r.pcNext = curPc + bImm;
                end
            opJal:
            begin
                r.wbEn   = 1'b1;
                r.wbData = curPc + 32'd4;
                r.pcNext = curPc + jImm;
                r.kind   = 3'd3;
            end
            opLui:
            begin
                r.wbEn   = 1'b1;
                r.wbData = {ins[31:12], 12'b0};
                r.kind   = 3'd1;
            end
            default: ;
        endcase
        if (r.kind == 3'd4 || ins[11:7] == 5'd0)
            r.wbEn = 1'b0; // x0 and no-ops never write
        if (!valid)
        begin
            r = '{pcNext: curPc, wbAddr: r.wbAddr, kind: 3'd4, default: '0};
        end
        return r;
    endfunction

    task automatic compareField(input int kind, input string what,
                                input logic [31:0] got, input logic [31:0] want);
        if (got !== want)
        begin
            errs[kind]++;
            $display("mismatch at %0t: %s expected %h, got %h, instr %h",
                     $time, what, want, got, instr);
        end
    endtask

    task automatic printTest(input int k);
        $display("%s: %0d cycles checked, %0d errors", testNames[k], checks[k], errs[k]);
    endtask

    // outputs are combinational from inputs driven at posedge, stable here
    always @(negedge clk)
    begin
        if (!arstN)
        begin
            modelPc = `RESET_PC;
            for (int i = 0; i < `REG_COUNT; i++)
                modelRegs[i] = '0;
            checks[0]++;
            compareField(0, "pc", pc, `RESET_PC);
            compareField(0, "wbEn", 32'(wbEn), 32'd0);
            compareField(0, "memWriteEn", 32'(memWriteEn), 32'd0);
        end
        else
        begin
            expected = refModel(instr, modelPc, modelRegs[instr[19:15]],
                                modelRegs[instr[24:20]], memRdata, instrValid);
            checks[expected.kind]++;
            compareField(expected.kind, "pc", pc, modelPc);
            compareField(expected.kind, "wbEn", 32'(wbEn), 32'(expected.wbEn));
            if (expected.wbEn)
            begin
                compareField(expected.kind, "wbAddr", 32'(wbAddr), 32'(expected.wbAddr));
                compareField(expected.kind, "wbData", wbData, expected.wbData);
                modelRegs[expected.wbAddr] = expected.wbData;
            end
            compareField(expected.kind, "memWriteEn", 32'(memWriteEn), 32'(expected.memWe));
            if (expected.chkAddr)
                compareField(expected.kind, "memAddr", memAddr, expected.memAddr);
            if (expected.memWe)
                compareField(expected.kind, "memWdata", memWdata, expected.memWdata);
            modelPc = expected.pcNext;
        end
    end

    always @(posedge arstN) printTest(0); // reset phase is over

    always @(posedge done)
    begin
        for (int k = 1; k < 5; k++)
            printTest(k);
    end

endmodule

// File: rvCorePkg.sv
package rvCorePkg;

    // major opcodes of the supported subset, standard RV32I encodings
    typedef enum logic [6:0] {
        opImm    = 7'b0010011, // addi
        opReg    = 7'b0110011, // add sub and or xor slt
        opLoad   = 7'b0000011, // lw
        opStore  = 7'b0100011, // sw
        opBranch = 7'b1100011, // beq bne
        opJal    = 7'b1101111,
        opLui    = 7'b0110111
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd   = 3'b000,
        aluSub   = 3'b001,
        aluAnd   = 3'b010,
        aluOr    = 3'b011,
        aluXor   = 3'b100,
        aluSlt   = 3'b101, // signed compare
        aluPassB = 3'b110  // lui passes the immediate
    } aluOpT;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immU = 3'b011,
        immJ = 3'b100
    } immSrcT;

endpackage

// File: rvCoreTb.sv
`timescale 1ns/10ps
`include "rvCore_macros.svh"

module rvCoreTb import rvCorePkg::*; ();

    localparam int RESET_CYCLES   = 16;
    localparam int NUM_INSTR      = 600;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_INSTR + 100; // margin for the tail

    logic                          clk = 1'b0;
    logic                          arstN;
    logic [`XLEN-1:0]              instr;
    logic                          instrValid;
    logic [`XLEN-1:0]              pc;
    logic                          wbEn;
    logic [$clog2(`REG_COUNT)-1:0] wbAddr;
    logic [`XLEN-1:0]              wbData;
    logic                          memWriteEn;
    logic [`XLEN-1:0]              memAddr;
    logic [`XLEN-1:0]              memWdata;
    logic [`XLEN-1:0]              memRdata;
    logic                          done;
    int                            errorTotal;
    int                            checkTotal;
    int                            cycleCount = 0;

    always #50 clk = ~clk; // 100 ns period

    rvCore uut (.*);

    rvCoreChecker uChecker (.*); // reference model and compare

    // one random instruction, registers kept to x0..x7 so results get reused
    function automatic logic [`XLEN-1:0] randomInstr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [12:0] bOff;
        logic [20:0] jOff;
        rd    = 5'($urandom_range(7));
        rs1   = 5'($urandom_range(7));
        rs2   = 5'($urandom_range(7));
        imm12 = 12'($urandom);
        bOff  = 13'($urandom_range(8) * 4 - 16); // -16 .. +16
        jOff  = 21'($urandom_range(8) * 4 - 16);
        case ($urandom_range(13))
            0:  return {imm12, rs1, 3'b000, rd, opImm}; // addi
            1:  return {7'b0000000, rs2, rs1, 3'b000, rd, opReg}; // add
            2:  return {7'b0100000, rs2, rs1, 3'b000, rd, opReg}; // sub
            3:  return {7'b0000000, rs2, rs1, 3'b111, rd, opReg}; // and
            4:  return {7'b0000000, rs2, rs1, 3'b110, rd, opReg}; // or
            5:  return {7'b0000000, rs2, rs1, 3'b100, rd, opReg}; // xor
            6:  return {7'b0000000, rs2, rs1, 3'b010, rd, opReg}; // slt
            7:  return {imm12, rs1, 3'b010, rd, opLoad}; // lw
            8:  return {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], opStore}; // sw
            9:  return {bOff[12], bOff[10:5], rs2, rs1, 3'b000, bOff[4:1], bOff[11], opBranch};
            10: return {bOff[12], bOff[10:5], rs2, rs1, 3'b001, bOff[4:1], bOff[11], opBranch};
            11: return {jOff[20], jOff[10:1], jOff[11], jOff[19:12], rd, opJal};
            12: return {20'($urandom), rd, opLui};
            default:
                if ($urandom_range(1) == 0)
                    return {20'($urandom), rd, 7'b0010111}; // auipc, not supported
                else
                    return {7'b0, rs2, rs1, 3'b001, rd, opImm}; // slli, not supported
        endcase
    endfunction

    initial
    begin
        arstN      = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        memRdata   = '0;
        done       = 1'b0;
        void'($urandom(32'h30a1));
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
        for (int n = 0; n < NUM_INSTR; n++)
        begin
            @(posedge clk);
            instrValid <= ($urandom_range(7) != 0); // about one stall in eight
            instr      <= randomInstr();
            memRdata   <= $urandom();
        end
        @(posedge clk);
        instrValid <= 1'b0;
        @(posedge clk); // last compare happened at the negedge before
        done = 1'b1;
        #1;
        $display("%0d cycles checked, %0d errors", checkTotal, errorTotal);
        if (errorTotal == 0 && checkTotal > 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

endmodule

// File: rvCore_macros.svh
`ifndef RVCORE_MACROS_SVH
`define RVCORE_MACROS_SVH

// datapath and address width
`define XLEN 32

// architectural registers, x0 included
`define REG_COUNT 32

`define RESET_PC 32'h0000_0000

`endif
